// ==== logic/rv_pkg.sv ====
package rv_pkg;

    ////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////
    localparam int xlen       = 32;    // data and address width
    localparam int reg_addr_w = 5;     // register index width
    localparam int num_regs   = 32;    // x0..x31
    localparam int pc_step    = 4;     // one word per instruction

    // funct7 patterns for r-type and shift-immediate
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;    // sub / sra / srai

    // funct3 codes the decoder needs to single out
    localparam logic [2:0] f3_add = 3'b000;    // add / sub / addi
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_sr  = 3'b101;    // srl / sra and immediate forms

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////
    // only the major opcodes this core executes
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,    // r-type alu
        op_imm   = 7'b0010011,    // i-type alu
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_and    = 4'b0000,
        alu_or     = 4'b0001,
        alu_add    = 4'b0010,
        alu_sll    = 4'b0011,
        alu_slt    = 4'b0100,
        alu_sltu   = 4'b0101,
        alu_sub    = 4'b0110,
        alu_xor    = 4'b0111,
        alu_srl    = 4'b1000,
        alu_sra    = 4'b1010,
        alu_pass_b = 4'b1111     // lui, result is operand b
    } alu_op_e;

    ////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////
    // decode to execute
    typedef struct packed {
        logic     valid;       // instruction writes rd
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        alu_op_e  alu_op;
        logic     src1_pc;     // operand a is the pc
        logic     src2_imm;    // operand b is the immediate
        xlen_t    rs1_data;
        xlen_t    rs2_data;
        xlen_t    imm;         // already sign extended
        xlen_t    pc;
    } id_ex_t;

    // register write / retired result
    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu import rv_pkg::*; (
    input  alu_op_e op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   result
);

    logic [4:0] shamt;    // shifts use the low five bits of b

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;    // zero fill
            end
            alu_sra: begin
                result = xlen_t'($signed(a) >>> shamt);    // sign fill
            end
            alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                result = {31'b0, a < b};
            end
            alu_pass_b: begin
                result = b;    // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== logic/fetch_decode.sv ====
`timescale 1ns/1ns

module fetch_decode import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  xlen_t    prg_data,    // word at pc, same cycle
    input  xlen_t    rs1_data,    // register file read data
    input  xlen_t    rs2_data,
    output xlen_t    pc,
    output reg_idx_t rs1,         // register file read addresses
    output reg_idx_t rs2,
    output id_ex_t   id_ex        // decode/execute register
);

    xlen_t      inst;       // fetch/decode register
    xlen_t      inst_pc;    // pc that fetched inst
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    logic       legal;      // opcode and funct fields recognized
    id_ex_t     id_ex_d;

    // funct3 to alu operation, alt picks sub / sra
    function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc      <= '0;
            inst    <= '0;    // all-zero word decodes as a bubble
            inst_pc <= '0;
        end else begin
            pc      <= pc + xlen_t'(pc_step);    // no stalls, no redirects
            inst    <= prg_data;
            inst_pc <= pc;
        end
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};    // sign extended 12 bits
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        legal            = 1'b0;
        id_ex_d          = '0;
        id_ex_d.rd       = rd;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.pc       = inst_pc;

        case (opcode)
            op_reg: begin
                id_ex_d.alu_op = f3_to_op(funct3, funct7[5]);
                // alt funct7 only exists for sub and sra
                legal = (funct7 == f7_base) ||
                        (funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr));
            end
            op_imm: begin
                id_ex_d.src2_imm = 1'b1;
                id_ex_d.imm      = imm_i;
                // bit 30 is immediate data except for srai
                id_ex_d.alu_op = f3_to_op(funct3, (funct3 == f3_sr) && funct7[5]);
                case (funct3)
                    f3_sll:  legal = (funct7 == f7_base);
                    f3_sr:   legal = (funct7 == f7_base) || (funct7 == f7_alt);
                    default: legal = 1'b1;
                endcase
            end
            op_lui: begin
                id_ex_d.src2_imm = 1'b1;
                id_ex_d.imm      = imm_u;
                id_ex_d.alu_op   = alu_pass_b;
                legal            = 1'b1;
            end
            op_auipc: begin
                id_ex_d.src1_pc  = 1'b1;    // pc + upper immediate
                id_ex_d.src2_imm = 1'b1;
                id_ex_d.imm      = imm_u;
                id_ex_d.alu_op   = alu_add;
                legal            = 1'b1;
            end
            default: legal = 1'b0;    // bubble or unsupported opcode
        endcase

        id_ex_d.valid = legal && (rd != '0);    // x0 writes are dropped here
    end

    // decode/execute register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  wb_t      wb,          // write port from writeback stage
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);

    xlen_t regs [num_regs];

    // x0 reads zero, a same-cycle write is passed through
    function automatic xlen_t read_port(input reg_idx_t idx, input wb_t wr, input xlen_t stored);
        if (idx == '0) return '0;
        if (wr.en && wr.rd == idx) return wr.data;
        return stored;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.rd] <= wb.data;    // en is never set for x0
        end
    end

    assign rs1_data = read_port(rs1, wb, regs[rs1]);
    assign rs2_data = read_port(rs2, wb, regs[rs2]);

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/1ns

module execute import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  id_ex_t id_ex,    // from decode/execute register
    output wb_t    wb        // writeback stage, also the register write port
);

    wb_t   mem_q;       // execute/memory register
    wb_t   wb_q;        // memory/writeback register
    xlen_t src1_val;    // rs1 after forwarding
    xlen_t src2_val;    // rs2 after forwarding
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_res;

    // newest producer wins, then the value read in decode
    function automatic xlen_t fwd(input reg_idx_t src, input xlen_t reg_val,
                                  input wb_t mem_s, input wb_t wb_s);
        if (mem_s.en && mem_s.rd == src) return mem_s.data;
        if (wb_s.en && wb_s.rd == src) return wb_s.data;
        return reg_val;
    endfunction

    ////////////////////////////////////////
    // operands
    ////////////////////////////////////////
    // en is already low for x0, so x0 never matches
    assign src1_val = fwd(id_ex.rs1, id_ex.rs1_data, mem_q, wb_q);
    assign src2_val = fwd(id_ex.rs2, id_ex.rs2_data, mem_q, wb_q);

    assign op_a = id_ex.src1_pc  ? id_ex.pc  : src1_val;    // auipc
    assign op_b = id_ex.src2_imm ? id_ex.imm : src2_val;

    alu u_alu (
        .op     (id_ex.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_res)
    );

    ////////////////////////////////////////
    // memory and writeback stages
    ////////////////////////////////////////
    // memory stage has no data access, only holds the result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            mem_q.en   <= id_ex.valid;
            mem_q.rd   <= id_ex.rd;
            mem_q.data <= alu_res;
            wb_q       <= mem_q;
        end
    end

    assign wb = wb_q;    // register file writes this at the next edge

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ns

module core_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  xlen_t prg_data,    // instruction at pc, combinational
    output xlen_t pc,
    output wb_t   wb           // retired result, one per cycle
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    id_ex_t   id_ex;

    ////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////
    fetch_decode u_fetch_decode (
        .clk      (clk),
        .rst      (rst),
        .prg_data (prg_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .id_ex    (id_ex)
    );

    // read in decode, written from writeback
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////////////////////////
    // execute, memory, writeback
    ////////////////////////////////////////
    execute u_execute (
        .clk   (clk),
        .rst   (rst),
        .id_ex (id_ex),
        .wb    (wb)
    );

endmodule

// ==== tb/tb_core_top.sv ====
`timescale 1ns/1ns

module tb_core_top import rv_pkg::*; ();

    logic   clk;
    logic   rst;
    xlen_t  prg_data;
    xlen_t  pc;
    wb_t    wb;

    xlen_t  prog [$];              // program image, one word per pc/4
    xlen_t  ref_regs [num_regs];   // architectural state of the model
    wb_t    exp_q [$];             // expected wb, oldest first
    integer seed;
    logic   prog_ready;

    core_top UUT (
        .clk      (clk),
        .rst      (rst),
        .prg_data (prg_data),
        .pc       (pc),
        .wb       (wb)
    );

    ////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////
    function automatic xlen_t r_word(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic xlen_t i_word(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic xlen_t u_word(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};    // lui or auipc
    endfunction

    // words past the end read as zero, a bubble
    function automatic xlen_t fetch_word(input xlen_t addr);
        int unsigned idx;
        idx = addr >> 2;
        if (idx < prog.size()) return prog[idx];
        return '0;
    endfunction

    ////////////////////////////////////////
    // reference model, one instruction in program order
    ////////////////////////////////////////
    function automatic wb_t run_reference(input xlen_t word, input xlen_t addr);
        wb_t        res;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] sh;
        reg_idx_t   rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        logic       ok;
        res = '0;
        f7  = word[31:25];
        f3  = word[14:12];
        sh  = word[24:20];                           // shamt of the immediate shifts
        rd  = word[11:7];
        a   = ref_regs[word[19:15]];
        b   = ref_regs[word[24:20]];
        imm = {{20{word[31]}}, word[31:20]};
        ok  = 1'b1;
        case (word[6:0])
            7'b0110011: begin
                case ({f7, f3})
                    {7'h00, 3'd0}: res.data = a + b;
                    {7'h20, 3'd0}: res.data = a - b;
                    {7'h00, 3'd1}: res.data = a << b[4:0];
                    {7'h00, 3'd2}: res.data = {31'b0, $signed(a) < $signed(b)};
                    {7'h00, 3'd3}: res.data = {31'b0, a < b};
                    {7'h00, 3'd4}: res.data = a ^ b;
                    {7'h00, 3'd5}: res.data = a >> b[4:0];
                    {7'h20, 3'd5}: res.data = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: res.data = a | b;
                    {7'h00, 3'd7}: res.data = a & b;
                    default:       ok = 1'b0;    // mul and friends not kept
                endcase
            end
            7'b0010011: begin
                case (f3)
                    3'd0: res.data = a + imm;
                    3'd2: res.data = {31'b0, $signed(a) < $signed(imm)};
                    3'd3: res.data = {31'b0, a < imm};    // imm sign extended, then unsigned
                    3'd4: res.data = a ^ imm;
                    3'd6: res.data = a | imm;
                    3'd7: res.data = a & imm;
                    3'd1: begin
                        ok       = (f7 == 7'h00);
                        res.data = a << sh;
                    end
                    default: begin
                        ok = (f7 == 7'h00) || (f7 == 7'h20);
                        if (f7[5]) begin
                            res.data = $signed(a) >>> sh;
                        end else begin
                            res.data = a >> sh;
                        end
                    end
                endcase
            end
            7'b0110111: res.data = {word[31:12], 12'b0};           // lui
            7'b0010111: res.data = addr + {word[31:12], 12'b0};    // auipc
            default:    ok = 1'b0;    // bubble or dropped opcode
        endcase
        if (ok && rd != '0) begin
            res.en       = 1'b1;
            res.rd       = rd;
            ref_regs[rd] = res.data;
        end else begin
            res = '0;
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic end_in_failure();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pc(input xlen_t act, input xlen_t exp);
        if (act !== exp) begin
            $display("FAIL t=%0t pc expected %h actual %h", $time, exp, act);
            end_in_failure();
        end
    endtask

    // rd and data only matter when a write is expected
    task automatic check_wb(input wb_t act, input wb_t exp);
        if (act.en !== exp.en) begin
            $display("FAIL t=%0t wb.en expected %b actual %b", $time, exp.en, act.en);
            end_in_failure();
        end else if (exp.en && act.rd !== exp.rd) begin
            $display("FAIL t=%0t wb.rd expected %0d actual %0d", $time, exp.rd, act.rd);
            end_in_failure();
        end else if (exp.en && act.data !== exp.data) begin
            $display("FAIL t=%0t wb.data expected %h actual %h", $time, exp.data, act.data);
            end_in_failure();
        end
    endtask

    ////////////////////////////////////////
    // program image
    ////////////////////////////////////////
    task automatic build_program();
        int r1;
        int r2;
        int rd;
        int rs1;
        int rs2;
        int f3;
        int f7;
        int alt;
        int kind;
        int imm;
        seed = 20035;
        prog.push_back(i_word(0, 1, 0, -5));              // addi x1, x0, -5
        prog.push_back(i_word(0, 2, 0, 7));               // addi x2, x0, 7
        prog.push_back(u_word(7'b0110111, 3, 'h80000));   // lui x3, 0x80000
        prog.push_back(i_word(0, 3, 3, 3));               // addi x3, x3, 3
        prog.push_back(i_word(0, 4, 0, -1));              // addi x4, x0, -1
        prog.push_back(r_word(0, 0, 5, 1, 2));            // add
        prog.push_back(r_word('h20, 0, 6, 1, 2));         // sub
        prog.push_back(r_word(0, 1, 7, 2, 1));            // sll, shamt 27 from -5
        prog.push_back(r_word(0, 2, 8, 1, 2));            // slt, -5 < 7
        prog.push_back(r_word(0, 3, 9, 1, 2));            // sltu
        prog.push_back(r_word(0, 4, 10, 1, 3));           // xor
        prog.push_back(r_word(0, 5, 11, 3, 2));           // srl
        prog.push_back(r_word('h20, 5, 12, 3, 2));        // sra
        prog.push_back(r_word(0, 6, 13, 1, 2));           // or
        prog.push_back(r_word(0, 7, 14, 4, 3));           // and
        prog.push_back(i_word(2, 15, 1, -3));             // slti
        prog.push_back(i_word(3, 16, 2, -1));             // sltiu against 0xffffffff
        prog.push_back(i_word(4, 17, 1, -1));             // xori, i.e. not
        prog.push_back(i_word(6, 18, 2, 'h7f0));          // ori
        prog.push_back(i_word(7, 19, 4, -16));            // andi
        prog.push_back(i_word(1, 20, 2, 31));             // slli
        prog.push_back(i_word(5, 21, 3, 4));              // srli
        prog.push_back(i_word(5, 22, 3, 'h404));          // srai
        prog.push_back(i_word(0, 23, 1, -2048));          // addi, most negative imm
        prog.push_back(u_word(7'b0110111, 24, 'h12345));  // lui
        prog.push_back(u_word(7'b0010111, 25, 'habcde));  // auipc
        prog.push_back(u_word(7'b0010111, 26, 0));        // auipc, pc only
        // dependence chain, distances one to three
        prog.push_back(r_word(0, 0, 27, 1, 2));
        prog.push_back(r_word(0, 0, 28, 27, 27));
        prog.push_back(r_word('h20, 0, 29, 28, 27));
        prog.push_back(r_word(0, 4, 30, 27, 29));
        prog.push_back(r_word(0, 0, 31, 28, 29));
        // no-write slots
        prog.push_back(32'h0000_0000);                    // bubble
        prog.push_back(32'hffff_ffff);                    // unknown opcode
        prog.push_back(32'h0000_a083);                    // lw x1, 0(x1) is not kept
        prog.push_back(r_word('h01, 0, 5, 1, 2));         // mul encoding
        prog.push_back(i_word(1, 6, 1, 'h405));           // slli with bad funct7
        prog.push_back(i_word(0, 0, 2, 100));             // addi x0
        prog.push_back(r_word(0, 0, 0, 2, 2));            // add x0
        prog.push_back(r_word(0, 0, 5, 0, 2));            // read x0 right after
        prog.push_back(r_word(0, 0, 6, 1, 1));            // x1 untouched by the lw

        // random kept types on x0..x7 so that hazards come often
        for (int i = 0; i < 200; i++) begin
            r1   = $random(seed);
            r2   = $random(seed);
            rd   = r1 & 7;
            rs1  = (r1 >> 3) & 7;
            rs2  = (r1 >> 6) & 7;
            f3   = (r1 >> 9) & 7;
            alt  = (r1 >> 12) & 1;
            kind = (r1 >> 13) & 7;
            if (kind < 3) begin
                f7 = 0;
                if (alt != 0 && (f3 == 0 || f3 == 5)) begin
                    f7 = 'h20;    // sub or sra
                end
                prog.push_back(r_word(f7, f3, rd, rs1, rs2));
            end else if (kind < 6) begin
                imm = r2;
                if (f3 == 1) begin
                    imm = r2 & 31;
                end else if (f3 == 5) begin
                    imm = (r2 & 31) + alt * 'h400;    // srai carries funct7 0x20
                end
                prog.push_back(i_word(f3, rd, rs1, imm));
            end else if (kind == 6) begin
                prog.push_back(u_word(7'b0110111, rd, r2));
            end else begin
                prog.push_back(u_word(7'b0010111, rd, r2));
            end
        end
    endtask

    ////////////////////////////////////////
    // clock, reset, stimulus
    ////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin : stimulus
        int cycle;
        rst        = 1'b0;
        prg_data   = '0;
        cycle      = 0;
        build_program();
        prog_ready = 1'b1;
        forever begin
            @(negedge clk);
            cycle++;
            if (cycle == 2) begin
                rst = 1'b1;    // two rising edges held in reset
            end
            prg_data = fetch_word(pc);    // stable until the capture edge
        end
    end

    initial begin : watchdog
        wait (prog_ready === 1'b1);
        #((prog.size() + 20) * 8);
        $display("watchdog expired before all results were compared");
        end_in_failure();
    end

    // samples on falling edges, where pc and wb are settled
    initial begin : compare
        xlen_t exp_pc;
        wb_t   slot;
        exp_pc  = '0;
        for (int i = 0; i < num_regs; i++) begin
            ref_regs[i] = '0;
        end
        @(negedge clk);
        check_pc(pc, '0);
        check_wb(wb, '0);
        wait (rst === 1'b1);
        repeat (prog.size() + 8) begin
            check_pc(pc, exp_pc);
            if (exp_q.size() == 4) begin
                slot = exp_q.pop_front();    // fetched four falling edges ago
                check_wb(wb, slot);
            end else begin
                check_wb(wb, '0);            // pipeline still filling
            end
            exp_q.push_back(run_reference(fetch_word(pc), pc));
            exp_pc = exp_pc + 32'd4;
            @(negedge clk);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/rv_pkg.sv
logic/alu.sv
logic/fetch_decode.sv
logic/reg_file.sv
logic/execute.sv
logic/core_top.sv
tb/tb_core_top.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

VFLAGS ?= --binary --timescale 1ns/1ns --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when a listed source, the list or this file changes
$(BIN): $(SRCS) $(FLIST) Makefile
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@grep -qx '>>> PASS' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
